// ==== eth_rx_defs.svh ====
`ifndef ETH_RX_DEFS_SVH
`define ETH_RX_DEFS_SVH

// Frame delimiter and CRC constants
`define ETH_SFD         8'hD5           // Start frame delimiter after the preamble
`define CRC_SEED        32'hFFFF_FFFF   // CRC register preset
`define CRC_RESIDUE     32'hC704_DD7B   // Remainder of a good frame in MSB-first form

// Receive FIFO geometry
`define RX_FIFO_DEPTH   16              // Entries
`define RX_FIFO_AW      4               // Pointer width for the depth above

// APB register map (byte offsets)
`define REG_FRAMES      4'h0            // Frames received
`define REG_BAD         4'h4            // Frames with CRC, PHY error or short
`define REG_DROPS       4'h8            // Bytes lost on FIFO overflow
`define REG_CTRL        4'hC            // Bit 0 enable, bit 1 clear counters

`endif

// ==== eth_frame_pkg.sv ====
`default_nettype none

package eth_frame_pkg;

    typedef logic [7:0]  eth_byte_t;    // One byte off the wire
    typedef logic [31:0] crc32_t;       // CRC register, reflected bit order

    // Receive MAC states
    typedef enum logic [1:0] {
        IDLE,                           // Hunting for the SFD
        FRAME,                          // Filling line and forwarding
        DRAIN                           // Closing byte plus status
    } rx_state_t;

endpackage

`default_nettype wire

// ==== eth_regs_pkg.sv ====
`default_nettype none

package eth_regs_pkg;

    typedef logic [3:0]  apb_addr_t;    // Byte address inside the block
    typedef logic [31:0] reg_data_t;    // APB data bus
    typedef logic [15:0] stat_cnt_t;    // Saturating statistics counter

endpackage

`default_nettype wire

// ==== axis_byte_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface axis_byte_if;
    import eth_frame_pkg::*;

    eth_byte_t tdata;                   // Frame byte
    logic      tvalid;                  // Byte moves this cycle, no ready
    logic      tlast;                   // Final byte of the frame
    logic      tuser;                   // Frame bad, valid with tlast only

    modport src  (output tdata, output tvalid, output tlast, output tuser);
    modport sink (input  tdata, input  tvalid, input  tlast, input  tuser);

endinterface

`default_nettype wire

// ==== crc32.sv ====
`timescale 1ns/1ps
`default_nettype none

// Byte step of the Ethernet CRC-32, LSB of each byte first
module crc32 (
    input  wire eth_frame_pkg::crc32_t    crc_in,     // Register before the byte
    input  wire eth_frame_pkg::eth_byte_t data,       // Byte in wire order
    output eth_frame_pkg::crc32_t         crc_out     // Register after the byte
);
    import eth_frame_pkg::*;

    localparam crc32_t POLY = 32'hEDB8_8320;          // 04C11DB7 bit-reversed

    always_comb begin
        crc32_t c;

        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            // Feedback bit is register LSB xor incoming data bit
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ POLY;
            end else begin
                c = c >> 1;
            end
        end
        crc_out = c;
    end

endmodule

`default_nettype wire

// ==== rx_mac.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "eth_rx_defs.svh"

module rx_mac (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire eth_frame_pkg::eth_byte_t rx_data,      // Byte from the PHY interface
    input  wire logic                     rx_dv,        // Byte valid
    input  wire logic                     rx_er,        // PHY signalled an error
    input  wire logic                     rx_enable,    // Sampled only at the SFD
    axis_byte_if.src                      out,          // To the FIFO
    output logic                          frame_done,   // One pulse per frame
    output logic                          frame_bad     // Qualifies frame_done
);
    import eth_frame_pkg::*;

    rx_state_t       state_q;
    eth_byte_t [3:0] line_q;            // Hold-back line with the oldest byte in [3]
    eth_byte_t       stage_q;           // Byte that left the line and waits for its tlast
    logic [2:0]      cnt_q;             // Bytes after SFD saturating at 5
    logic            err_q;             // Sticky rx_er
    crc32_t          crc_q;
    crc32_t          crc_next;
    crc32_t          crc_msb;           // Register in residue bit order
    logic            take;              // Frame byte accepted this cycle
    logic            long_frame;        // stage_q holds a real byte

    crc32 u_crc (
        .crc_in  (crc_q),
        .data    (rx_data),
        .crc_out (crc_next)
    );

    assign take       = (state_q == FRAME) && rx_dv;
    assign long_frame = (cnt_q == 3'd5);
    assign crc_msb    = {<<{crc_q}};    // Reflected register back to MSB-first

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    // Enable gates only the start so a running frame completes
                    if (rx_dv && rx_enable && (rx_data == `ETH_SFD)) begin
                        state_q <= FRAME;
                        cnt_q   <= '0;
                        err_q   <= 1'b0;
                    end
                end
                FRAME: begin
                    if (rx_dv) begin
                        if (!long_frame) begin
                            cnt_q <= cnt_q + 3'd1;
                        end
                        err_q <= err_q | rx_er;
                    end else begin
                        state_q <= DRAIN;       // First idle cycle ends the frame
                    end
                end
                DRAIN:   state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            crc_q <= `CRC_SEED;                 // Preset while hunting
        end else if (take) begin
            crc_q <= crc_next;                  // FCS bytes included
        end
        if (take) begin
            line_q <= {line_q[2:0], rx_data};
            if (cnt_q >= 3'd4) begin
                stage_q <= line_q[3];           // Oldest byte moves on once the line is full
            end
        end
    end

    // Bad on CRC mismatch, PHY error or too few bytes for an FCS
    assign frame_bad  = err_q || !long_frame || (crc_msb != `CRC_RESIDUE);
    assign frame_done = (state_q == DRAIN);

    // Staged byte goes out when the next one arrives or in DRAIN as the last
    assign out.tdata  = stage_q;
    assign out.tvalid = long_frame && (take || (state_q == DRAIN));
    assign out.tlast  = (state_q == DRAIN);
    assign out.tuser  = (state_q == DRAIN) && frame_bad;

    // Mid-frame bytes leave five takes after they entered the line
    a_hold_back: assert property (@(posedge clk) disable iff (!reset_n)
        out.tvalid && !out.tlast |-> $past(take, 5))
        else $error("byte forwarded before four newer bytes were held back");

    a_end_latency: assert property (@(posedge clk) disable iff (!reset_n)
        frame_done |-> out.tlast && $past(!rx_dv) && $past(rx_dv, 2))
        else $error("frame end not one cycle after rx_dv fell");

endmodule

`default_nettype wire

// ==== rx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "eth_rx_defs.svh"

module rx_fifo (
    input  wire logic                clk,
    input  wire logic                reset_n,
    axis_byte_if.sink                in,            // From the MAC which cannot stall
    output eth_frame_pkg::eth_byte_t m_tdata,
    output logic                     m_tvalid,
    input  wire logic                m_tready,
    output logic                     m_tlast,
    output logic                     m_tuser,
    output logic                     overflow       // Byte dropped this cycle
);
    localparam logic [`RX_FIFO_AW:0] FILL_MAX = (`RX_FIFO_AW + 1)'(`RX_FIFO_DEPTH);

    logic [9:0]             mem_q [`RX_FIFO_DEPTH]; // {byte, last, user}
    logic [`RX_FIFO_AW-1:0] wr_ptr_q;
    logic [`RX_FIFO_AW-1:0] rd_ptr_q;
    logic [`RX_FIFO_AW:0]   fill_q;
    logic                   full;
    logic                   rd_en;
    logic                   wr_en;

    assign full     = (fill_q == FILL_MAX);
    assign rd_en    = m_tvalid && m_tready;
    assign wr_en    = in.tvalid && (!full || rd_en);    // Read frees a slot when full
    assign overflow = in.tvalid && full && !rd_en;
    assign m_tvalid = (fill_q != '0);
    assign {m_tdata, m_tlast, m_tuser} = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= {in.tdata, in.tlast, in.tuser};
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;            // Wraps at the depth
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;              // Both or neither
            endcase
        end
    end

    a_no_read_empty: assert property (@(posedge clk) disable iff (!reset_n)
        rd_en |-> (rd_ptr_q != wr_ptr_q) || full)
        else $error("FIFO read while the pointers show it empty");

    a_fill_bound: assert property (@(posedge clk) disable iff (!reset_n)
        (fill_q <= FILL_MAX) && (fill_q[`RX_FIFO_AW-1:0] == wr_ptr_q - rd_ptr_q))
        else $error("FIFO fill count out of range or out of step with pointers");

endmodule

`default_nettype wire

// ==== rx_stats_apb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "eth_rx_defs.svh"

module rx_stats_apb (
    input  wire logic                    clk,
    input  wire logic                    reset_n,
    input  wire logic                    psel,
    input  wire logic                    penable,
    input  wire logic                    pwrite,
    input  wire eth_regs_pkg::apb_addr_t paddr,
    input  wire eth_regs_pkg::reg_data_t pwdata,
    output eth_regs_pkg::reg_data_t      prdata,
    output logic                         pready,     // No wait states
    input  wire logic                    frame_done,
    input  wire logic                    frame_bad,
    input  wire logic                    overflow,
    output logic                         rx_enable
);
    import eth_regs_pkg::*;

    stat_cnt_t frames_q;
    stat_cnt_t bad_q;
    stat_cnt_t drops_q;
    logic      wr_ctrl;                 // Access phase write to REG_CTRL
    logic      clear;

    // Count up unless already at all ones
    function automatic stat_cnt_t sat_inc(input stat_cnt_t cnt, input logic ev);
        return (ev && (cnt != '1)) ? cnt + 1'b1 : cnt;
    endfunction

    assign pready  = 1'b1;
    assign wr_ctrl = psel && penable && pwrite && (paddr == `REG_CTRL);
    assign clear   = wr_ctrl && pwdata[1];  // Wins over a same-cycle event

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            frames_q  <= '0;
            bad_q     <= '0;
            drops_q   <= '0;
            rx_enable <= 1'b1;          // Receiving out of reset
        end else begin
            if (clear) begin
                frames_q <= '0;
                bad_q    <= '0;
                drops_q  <= '0;
            end else begin
                frames_q <= sat_inc(frames_q, frame_done);
                bad_q    <= sat_inc(bad_q, frame_done && frame_bad);
                drops_q  <= sat_inc(drops_q, overflow);
            end
            if (wr_ctrl) begin
                rx_enable <= pwdata[0];
            end
        end
    end

    // Counters read zero-extended, writes to them fall through
    always_comb begin
        case (paddr)
            `REG_FRAMES: prdata = reg_data_t'(frames_q);
            `REG_BAD:    prdata = reg_data_t'(bad_q);
            `REG_DROPS:  prdata = reg_data_t'(drops_q);
            `REG_CTRL:   prdata = reg_data_t'(rx_enable);
            default:     prdata = '0;
        endcase
    end

    a_apb_phases: assert property (@(posedge clk) disable iff (!reset_n)
        penable |-> psel && $past(psel))
        else $error("APB access phase without select or setup");

endmodule

`default_nettype wire

// ==== eth_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_rx_top (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire eth_frame_pkg::eth_byte_t rx_data,     // PHY side
    input  wire logic                     rx_dv,
    input  wire logic                     rx_er,
    output eth_frame_pkg::eth_byte_t      m_tdata,     // Output stream
    output logic                          m_tvalid,
    input  wire logic                     m_tready,
    output logic                          m_tlast,
    output logic                          m_tuser,
    input  wire logic                     psel,        // Register port
    input  wire logic                     penable,
    input  wire logic                     pwrite,
    input  wire eth_regs_pkg::apb_addr_t  paddr,
    input  wire eth_regs_pkg::reg_data_t  pwdata,
    output eth_regs_pkg::reg_data_t       prdata,
    output logic                          pready
);
    logic frame_done;
    logic frame_bad;
    logic overflow;
    logic rx_enable;

    axis_byte_if rx_bus ();             // MAC to FIFO

    rx_mac u_mac (
        .clk        (clk),
        .reset_n    (reset_n),
        .rx_data    (rx_data),
        .rx_dv      (rx_dv),
        .rx_er      (rx_er),
        .rx_enable  (rx_enable),
        .out        (rx_bus.src),
        .frame_done (frame_done),
        .frame_bad  (frame_bad)
    );

    rx_fifo u_fifo (
        .clk      (clk),
        .reset_n  (reset_n),
        .in       (rx_bus.sink),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser),
        .overflow (overflow)
    );

    rx_stats_apb u_stats (
        .clk        (clk),
        .reset_n    (reset_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .frame_done (frame_done),
        .frame_bad  (frame_bad),
        .overflow   (overflow),
        .rx_enable  (rx_enable)
    );

endmodule

`default_nettype wire

// ==== tb_eth_rx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "eth_rx_defs.svh"

module tb_eth_rx;
    import eth_frame_pkg::*;
    import eth_regs_pkg::*;

    localparam int STIM_WORDS = 256;    // Room for the whole stimulus file
    localparam int GAP_CYCLES = 80;     // Drain and register reads per frame
    localparam int IFG        = 12;     // Idle cycles after each frame
    localparam int M_GOOD = 0, M_CORRUPT = 1, M_PHYERR = 2, M_SHORT = 3;
    localparam int M_OFF = 4, M_STALL = 5, M_CLEAR = 6;

    logic clk = 1'b0;
    logic reset_n;
    eth_byte_t rx_data;
    logic rx_dv, rx_er;
    eth_byte_t m_tdata;
    logic m_tvalid, m_tready, m_tlast, m_tuser;
    logic psel, penable, pwrite, pready;
    apb_addr_t paddr;
    reg_data_t pwdata, prdata;

    logic [15:0] stim [0:STIM_WORDS-1]; // Flat word list from the stimulus file
    eth_byte_t   frame_buf [0:63];      // Current frame with FCS appended
    logic [9:0]  exp_q [$];             // {byte, last, user} awaited at the output
    logic [9:0]  mon_exp;
    logic [15:0] lfsr_state;
    logic        stall, hold_ready, bit_a, bit_b;
    int errors = 0, checks = 0, cycles = 0, cycle_limit;

    eth_rx_top UUT (.*);

    always #2 clk = ~clk;               // 4 ns period

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Ethernet FCS over frame_buf[0..n-1] reflected and inverted at the end
    function automatic logic [31:0] frame_fcs(input int n);
        logic [31:0] c;
        c = `CRC_SEED;
        for (int i = 0; i < n; i++) begin
            c = c ^ {24'h0, frame_buf[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    function automatic string mode_name(input int m);
        case (m)
            M_GOOD:    return "good";
            M_CORRUPT: return "crc error";
            M_PHYERR:  return "rx_er";
            M_SHORT:   return "short";
            M_OFF:     return "disabled";
            M_STALL:   return "stalled";
            default:   return "clear";
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;                             // Inputs change just after the edge
    endtask

    task automatic apb_write(input apb_addr_t addr, input reg_data_t data);
        psel   = 1'b1;                  // Setup phase
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        tick();
        penable = 1'b1;                 // Access phase without wait states
        tick();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output reg_data_t data);
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        tick();
        penable = 1'b1;
        @(negedge clk);
        data = prdata;                  // Sampled mid-cycle away from the edge
        check("pready", 32'h1, 32'(pready));
        tick();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_counters(input int frames, input int bad, input int drops);
        reg_data_t v;
        apb_read(`REG_FRAMES, v);
        check("REG_FRAMES", 32'(frames), v);
        apb_read(`REG_BAD, v);
        check("REG_BAD", 32'(bad), v);
        apb_read(`REG_DROPS, v);
        check("REG_DROPS", 32'(drops), v);
    endtask

    // Preamble and SFD then n bytes of frame_buf with rx_er on byte er_pos
    task automatic send_frame(input int n, input int er_pos);
        rx_dv = 1'b1;
        for (int i = 0; i < 7; i++) begin
            rx_data = 8'h55;
            tick();
        end
        rx_data = `ETH_SFD;
        tick();
        for (int i = 0; i < n; i++) begin
            rx_data = frame_buf[i];
            rx_er   = (i == er_pos);
            tick();
        end
        rx_dv   = 1'b0;
        rx_er   = 1'b0;
        rx_data = '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || m_tvalid) begin
            tick();                     // Timeout block catches a stuck output
        end
    endtask

    // Ready about three cycles in four from two LFSR bits per cycle
    always @(posedge clk) begin
        hold_ready = stall;             // stall only moves after the edge
        #1;
        if (hold_ready) begin
            m_tready = 1'b0;
        end else begin
            bit_a = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            bit_b = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            m_tready = !(bit_a && bit_b);
        end
    end

    // Transfer seen at negedge happens at the coming rising edge
    always @(negedge clk) begin
        if (reset_n && m_tvalid && m_tready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output byte %0h at %0t ns while no byte was expected", m_tdata, $time);
            end else begin
                mon_exp = exp_q.pop_front();
                check("m_tdata", 32'(mon_exp[9:2]), 32'(m_tdata));
                check("m_tlast", 32'(mon_exp[1]), 32'(m_tlast));
                check("m_tuser", 32'(mon_exp[0]), 32'(m_tuser));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not end within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int idx, len, mode, pos, n_bytes, n_out, base_err, test_num;
        int exp_frames, exp_bad, exp_drops;
        logic exp_user, last;
        logic [31:0] fcs;
        reg_data_t ctrl;

        reset_n    = 1'b0;
        rx_data    = '0;
        rx_dv      = 1'b0;
        rx_er      = 1'b0;
        m_tready   = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        stall      = 1'b0;
        lfsr_state = 16'd30332;
        $readmemh("eth_rx_stimulus.txt", stim);
        idx = 0;
        cycle_limit = 16;               // Reset
        while (idx < STIM_WORDS - 1 && stim[idx] !== 16'hFFFF) begin
            cycle_limit += int'(stim[idx+1]) + IFG + GAP_CYCLES;
            idx += 6 + int'(stim[idx+1]);
        end
        cycle_limit *= 2;
        repeat (16) @(posedge clk);
        #1 reset_n = 1'b1;

        idx = 0;
        test_num = 0;
        while (idx < STIM_WORDS - 1 && stim[idx] !== 16'hFFFF) begin
            mode = int'(stim[idx][15:8]);   // Low byte is the corrupt or rx_er position
            pos  = int'(stim[idx][7:0]);
            len  = int'(stim[idx+1]);
            for (int i = 0; i < len; i++) begin
                frame_buf[i] = stim[idx+2+i][7:0];
            end
            exp_user   = stim[idx+2+len][0];
            exp_frames = int'(stim[idx+3+len]);
            exp_bad    = int'(stim[idx+4+len]);
            exp_drops  = int'(stim[idx+5+len]);
            idx += 6 + len;
            test_num++;
            base_err = errors;
            if (mode == M_CLEAR) begin
                apb_write(`REG_CTRL, 32'h3);        // Keep enable and clear counters
            end else begin
                if (mode == M_OFF) begin
                    apb_write(`REG_CTRL, 32'h0);
                    apb_read(`REG_CTRL, ctrl);
                    check("REG_CTRL", 32'h0, ctrl);
                end
                if (mode == M_STALL) stall = 1'b1;
                n_bytes = len;
                if (mode != M_SHORT) begin
                    fcs = frame_fcs(len);
                    for (int k = 0; k < 4; k++) begin
                        frame_buf[len+k] = fcs[8*k +: 8];   // FCS goes out LSB byte first
                    end
                    n_bytes = len + 4;
                end
                if (mode == M_CORRUPT) frame_buf[pos] = frame_buf[pos] ^ 8'hFF;
                n_out = (mode == M_SHORT || mode == M_OFF) ? 0 : len;
                if (mode == M_STALL && n_out > `RX_FIFO_DEPTH) n_out = `RX_FIFO_DEPTH;
                for (int i = 0; i < n_out; i++) begin
                    last = (i == len - 1);
                    exp_q.push_back({frame_buf[i], last, last && exp_user});
                end
                send_frame(n_bytes, (mode == M_PHYERR) ? pos : -1);
                repeat (IFG) tick();
            end
            if (mode != M_STALL) wait_drain();
            check_counters(exp_frames, exp_bad, exp_drops);
            stall = 1'b0;                           // Stalled bytes drain from here
            wait_drain();
            if (mode == M_OFF) begin
                apb_write(`REG_CTRL, 32'h1);
                apb_read(`REG_CTRL, ctrl);
                check("REG_CTRL", 32'h1, ctrl);
            end
            $display("test %0d %s: %0d errors", test_num, mode_name(mode), errors - base_err);
        end
        if (test_num == 0 || idx >= STIM_WORDS - 1) begin
            errors++;
            $display("Stimulus file has no frames or no end marker");
        end
        repeat (4) tick();
        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== eth_rx_stimulus.txt ====
// Per frame: mode word (mode in high byte, corrupt or rx_er byte position in low byte),
// length, bytes without FCS, expected tuser, expected REG_FRAMES, REG_BAD, REG_DROPS
// Modes 0 good, 1 crc error, 2 rx_er, 3 short, 4 disabled, 5 stalled, 6 clear; FFFF ends
0000 000A 01 02 03 04 05 06 10 20 30 40 0 0001 0000 0000
0000 0011 00 1b 21 3c 4d 5e 02 aa bb cc dd ee 08 00 45 00 2c 0 0002 0000 0000
0000 0001 7e 0 0003 0000 0000
// Byte 4 flipped after the FCS is built
0104 000C de ad be ef 00 01 02 03 04 05 06 07 1 0004 0001 0000
// rx_er high on byte 6
0206 000E a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad 1 0005 0002 0000
// Three bytes after the SFD, no FCS
0300 0003 11 22 33 0 0006 0003 0000
// Receive disabled around this frame
0400 000A 55 66 77 88 99 aa bb cc dd ee 0 0006 0003 0000
// Output held off, 24 bytes into a 16-entry FIFO
0500 0018 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 0 0007 0003 0008
0600 0000 0 0000 0000 0000
0000 0014 c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf d0 d1 d2 d3 0 0001 0000 0000
FFFF

// ==== tb.f ====
+incdir+.
eth_frame_pkg.sv
eth_regs_pkg.sv
axis_byte_if.sv
crc32.sv
rx_mac.sv
rx_fifo.sv
rx_stats_apb.sv
eth_rx_top.sv
tb_eth_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Ethernet receive testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_eth_rx -o sim_eth_rx \
    > build.log 2>&1 \
    && ./obj_dir/sim_eth_rx > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
exit 0
